// ==== common/lcd_pkg.sv ====
package lcd_pkg;

    typedef logic [7:0] lcd_byte_t;

    // HD44780 commands, 8-bit bus, two lines, 5x8 font
    localparam lcd_byte_t CMD_FUNCTION_SET = 8'h38;
    localparam lcd_byte_t CMD_DISPLAY_ON   = 8'h0C;
    localparam lcd_byte_t CMD_CLEAR        = 8'h01;
    localparam lcd_byte_t CGRAM_BASE       = 8'h40;
    // DDRAM addresses on line 1
    localparam lcd_byte_t CURSOR_FACE      = 8'h80;
    localparam lcd_byte_t CURSOR_TEXT      = 8'h82;

    localparam int GLYPH_ROWS  = 8;
    localparam int TEXT_LENGTH = 12;

    typedef enum logic [3:0] {
        SEQ_POWER_UP,
        SEQ_INIT,
        SEQ_CGRAM_ADDR,
        SEQ_GLYPH,
        SEQ_FACE_CURSOR,
        SEQ_FACE_CHAR,
        SEQ_TEXT_CURSOR,
        SEQ_TEXT,
        SEQ_IDLE
    } seq_state_t;

endpackage

// ==== common/lcd_write_if.sv ====
interface lcd_write_if;

    // Four-phase handshake, rs and data stable while req is high
    logic              req;
    logic              rs;
    lcd_pkg::lcd_byte_t data;
    logic              ack;

    modport sequencer (
        output req,
        output rs,
        output data,
        input  ack
    );

    modport timer (
        input  req,
        input  rs,
        input  data,
        output ack
    );

endinterface

// ==== common/pet_pkg.sv ====
package pet_pkg;

    // One pet statistic, 0 to 5
    typedef logic [3:0] stat_t;

    // Ticks since reset release
    typedef logic [15:0] tick_count_t;

    // Listed in selection priority, happy is the fallback
    typedef enum logic [2:0] {
        MOOD_DEAD,
        MOOD_ASLEEP,
        MOOD_SAD,
        MOOD_SICK,
        MOOD_HUNGRY,
        MOOD_TIRED,
        MOOD_BORED,
        MOOD_HAPPY
    } mood_t;

    localparam stat_t STAT_MAX = 4'd5;
    localparam stat_t STAT_LOW = 4'd2;

    // Rule periods in ticks, powers of two
    localparam tick_count_t HUNGER_PERIOD = 16'd4;
    localparam tick_count_t FUN_PERIOD    = 16'd4;
    localparam tick_count_t ENERGY_PERIOD = 16'd8;
    localparam tick_count_t REST_PERIOD   = 16'd2;
    localparam tick_count_t HAPPY_PERIOD  = 16'd4;
    localparam tick_count_t LIFE_PERIOD   = 16'd8;

endpackage

// ==== lcd/lcd_bus_timer.sv ====
module lcd_bus_timer #(
    parameter int e_pulse_cycles = 25,
    parameter int e_gap_cycles   = 2500
) (
    input  logic               clk,
    input  logic               reset,
    lcd_write_if.timer         wr,
    output logic               lcd_rs,
    output lcd_pkg::lcd_byte_t lcd_data,
    output logic               lcd_e
);

    localparam int MAX_CYCLES = (e_pulse_cycles > e_gap_cycles) ? e_pulse_cycles : e_gap_cycles;
    localparam int CW = $clog2(MAX_CYCLES + 1);

    typedef enum logic [1:0] {
        PH_IDLE,
        PH_PULSE,
        PH_GAP,
        PH_ACK
    } phase_t;

    phase_t        phase;
    logic [CW-1:0] count;

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            phase    <= PH_IDLE;
            count    <= '0;
            lcd_e    <= 1'b0;
            lcd_rs   <= 1'b0;
            lcd_data <= '0;
            wr.ack   <= 1'b0;
        end else begin
            case (phase)
                PH_IDLE: begin
                    if (wr.req) begin
                        lcd_rs   <= wr.rs;
                        lcd_data <= wr.data;
                        lcd_e    <= 1'b1;
                        count    <= CW'(e_pulse_cycles - 1);
                        phase    <= PH_PULSE;
                    end
                end
                PH_PULSE: begin
                    if (count == '0) begin
                        lcd_e <= 1'b0;
                        count <= CW'(e_gap_cycles - 1);
                        phase <= PH_GAP;
                    end else begin
                        count <= count - 1'b1;
                    end
                end
                PH_GAP: begin
                    // Recovery time before the byte counts as done
                    if (count == '0) begin
                        wr.ack <= 1'b1;
                        phase  <= PH_ACK;
                    end else begin
                        count <= count - 1'b1;
                    end
                end
                default: begin
                    if (!wr.req) begin
                        wr.ack <= 1'b0;
                        phase  <= PH_IDLE;
                    end
                end
            endcase
        end
    end

endmodule

// ==== lcd/lcd_sequencer.sv ====
module lcd_sequencer #(
    parameter int power_up_cycles = 2_000_000
) (
    input  logic           clk,
    input  logic           reset,
    input  pet_pkg::mood_t mood,
    lcd_write_if.sequencer wr
);
    import pet_pkg::*;
    import lcd_pkg::*;

    localparam int PW = $clog2(power_up_cycles + 1);
    // Custom glyph lives at character code 0
    localparam lcd_byte_t FACE_CODE = 8'h00;

    seq_state_t      state;
    logic [PW-1:0]   power_count;
    logic [1:0]      init_index;
    logic [2:0]      glyph_row;
    logic [3:0]      text_index;
    mood_t           drawn_mood;
    lcd_byte_t       glyph_byte;
    lcd_byte_t       text_byte;
    lcd_byte_t       init_cmd;
    lcd_byte_t       cur_byte;
    logic            cur_rs;
    logic            sending;
    logic            launch;
    logic            done;

    mood_rom u_rom (
        .clk        (clk),
        .mood       (drawn_mood),
        .glyph_row  (glyph_row),
        .text_index (text_index),
        .glyph_byte (glyph_byte),
        .text_byte  (text_byte)
    );

    // Indexes change on the req drop edge, the ack fall that follows
    // gives the ROM its clock before the next launch
    assign sending = (state != SEQ_POWER_UP) && (state != SEQ_IDLE);
    assign launch  = sending && !wr.req && !wr.ack;
    assign done    = wr.req && wr.ack;

    always_comb begin
        case (init_index)
            2'd0:    init_cmd = CMD_FUNCTION_SET;
            2'd1:    init_cmd = CMD_DISPLAY_ON;
            default: init_cmd = CMD_CLEAR;
        endcase
    end

    always_comb begin
        cur_rs   = 1'b0;
        cur_byte = CURSOR_FACE;
        case (state)
            SEQ_INIT:        cur_byte = init_cmd;
            SEQ_CGRAM_ADDR:  cur_byte = CGRAM_BASE;
            SEQ_TEXT_CURSOR: cur_byte = CURSOR_TEXT;
            SEQ_GLYPH: begin
                cur_rs   = 1'b1;
                cur_byte = glyph_byte;
            end
            SEQ_FACE_CHAR: begin
                cur_rs   = 1'b1;
                cur_byte = FACE_CODE;
            end
            SEQ_TEXT: begin
                cur_rs   = 1'b1;
                cur_byte = text_byte;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (launch) begin
            wr.rs   <= cur_rs;
            wr.data <= cur_byte;
        end
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            state       <= SEQ_POWER_UP;
            wr.req      <= 1'b0;
            power_count <= '0;
            init_index  <= '0;
            glyph_row   <= '0;
            text_index  <= '0;
            drawn_mood  <= MOOD_HAPPY;
        end else begin
            case (state)
                SEQ_POWER_UP: begin
                    if (power_count == PW'(power_up_cycles - 1))
                        state <= SEQ_INIT;
                    else
                        power_count <= power_count + 1'b1;
                end
                SEQ_IDLE: begin
                    // Redraw skips the init commands
                    if (mood != drawn_mood) begin
                        drawn_mood <= mood;
                        state      <= SEQ_CGRAM_ADDR;
                    end
                end
                default: begin
                    if (launch) begin
                        wr.req <= 1'b1;
                    end else if (done) begin
                        wr.req <= 1'b0;
                        case (state)
                            SEQ_INIT: begin
                                if (init_index == 2'd2) begin
                                    drawn_mood <= mood;
                                    state      <= SEQ_CGRAM_ADDR;
                                end else begin
                                    init_index <= init_index + 2'd1;
                                end
                            end
                            SEQ_CGRAM_ADDR: begin
                                glyph_row <= '0;
                                state     <= SEQ_GLYPH;
                            end
                            SEQ_GLYPH: begin
                                if (glyph_row == 3'(GLYPH_ROWS - 1))
                                    state <= SEQ_FACE_CURSOR;
                                else
                                    glyph_row <= glyph_row + 3'd1;
                            end
                            SEQ_FACE_CURSOR: state <= SEQ_FACE_CHAR;
                            SEQ_FACE_CHAR: begin
                                text_index <= '0;
                                state      <= SEQ_TEXT_CURSOR;
                            end
                            SEQ_TEXT_CURSOR: state <= SEQ_TEXT;
                            default: begin
                                if (text_index == 4'(TEXT_LENGTH - 1))
                                    state <= SEQ_IDLE;
                                else
                                    text_index <= text_index + 4'd1;
                            end
                        endcase
                    end
                end
            endcase
        end
    end

endmodule

// ==== lcd/mood_glyphs.mem ====
// Eight 5-bit glyph rows per mood, top row first, moods in mood_t order
00 1B 0A 1B 00 0E 11 00 // dead
00 00 1B 00 00 0E 00 00 // asleep
00 0A 0A 00 00 0E 11 00 // sad
00 0A 0A 00 1F 15 00 00 // sick
00 0A 0A 00 0E 11 0E 00 // hungry
00 00 1B 0A 00 0E 00 00 // tired
00 0A 0A 00 00 1F 00 00 // bored
00 0A 0A 00 11 0E 00 00 // happy

// ==== lcd/mood_rom.sv ====
module mood_rom (
    input  logic               clk,
    input  pet_pkg::mood_t     mood,
    input  logic [2:0]         glyph_row,
    input  logic [3:0]         text_index,
    output lcd_pkg::lcd_byte_t glyph_byte,
    output lcd_pkg::lcd_byte_t text_byte
);
    import pet_pkg::*;
    import lcd_pkg::*;

    localparam int MOODS = 2 ** $bits(mood_t);

    lcd_byte_t glyph_mem [0:MOODS*GLYPH_ROWS-1];
    lcd_byte_t text_mem  [0:MOODS*TEXT_LENGTH-1];

    logic [5:0] glyph_addr;
    logic [6:0] text_addr;

    // One line per mood in both files, in mood_t order
    initial begin
        $readmemh("lcd/mood_glyphs.mem", glyph_mem);
        $readmemh("lcd/mood_text.mem", text_mem);
    end

    assign glyph_addr = {mood, glyph_row};
    assign text_addr  = 7'(mood) * 7'(TEXT_LENGTH) + 7'(text_index);

    always_ff @(posedge clk) begin
        glyph_byte <= glyph_mem[glyph_addr];
        text_byte  <= text_mem[text_addr];
    end

endmodule

// ==== lcd/mood_text.mem ====
// Twelve ASCII bytes of mood text per mood, space padded, moods in mood_t order
44 45 41 44 20 20 20 20 20 20 20 20 // DEAD
41 53 4C 45 45 50 20 20 20 20 20 20 // ASLEEP
53 41 44 20 20 20 20 20 20 20 20 20 // SAD
53 49 43 4B 20 20 20 20 20 20 20 20 // SICK
48 55 4E 47 52 59 20 20 20 20 20 20 // HUNGRY
54 49 52 45 44 20 20 20 20 20 20 20 // TIRED
42 4F 52 45 44 20 20 20 20 20 20 20 // BORED
48 41 50 50 59 20 20 20 20 20 20 20 // HAPPY

// ==== logic/pet_top.sv ====
module pet_top #(
    parameter int tick_cycles     = 50_000_000,
    parameter int power_up_cycles = 2_000_000,
    parameter int e_pulse_cycles  = 25,
    parameter int e_gap_cycles    = 2500
) (
    input  logic               clk,
    input  logic               reset,
    input  logic               presence,
    input  logic               play,
    input  logic               feed_n,
    input  logic               heal_n,
    output logic               lcd_rs,
    output logic               lcd_rw,
    output logic               lcd_e,
    output lcd_pkg::lcd_byte_t lcd_data,
    output pet_pkg::stat_t     hunger,
    output pet_pkg::stat_t     fun,
    output pet_pkg::stat_t     energy,
    output pet_pkg::stat_t     happiness,
    output pet_pkg::stat_t     life
);
    import pet_pkg::*;

    logic  awake;
    logic  feed_press;
    logic  heal_press;
    logic  play_press;
    mood_t mood;

    lcd_write_if lcd_bus ();

    button_sync u_sync (
        .clk        (clk),
        .reset      (reset),
        .presence   (presence),
        .play       (play),
        .feed_n     (feed_n),
        .heal_n     (heal_n),
        .awake      (awake),
        .feed_press (feed_press),
        .heal_press (heal_press),
        .play_press (play_press)
    );

    pet_stats #(
        .tick_cycles (tick_cycles)
    ) u_stats (
        .clk        (clk),
        .reset      (reset),
        .awake      (awake),
        .feed_press (feed_press),
        .heal_press (heal_press),
        .play_press (play_press),
        .hunger     (hunger),
        .fun        (fun),
        .energy     (energy),
        .happiness  (happiness),
        .life       (life),
        .mood       (mood)
    );

    lcd_sequencer #(
        .power_up_cycles (power_up_cycles)
    ) u_sequencer (
        .clk   (clk),
        .reset (reset),
        .mood  (mood),
        .wr    (lcd_bus.sequencer)
    );

    lcd_bus_timer #(
        .e_pulse_cycles (e_pulse_cycles),
        .e_gap_cycles   (e_gap_cycles)
    ) u_timer (
        .clk      (clk),
        .reset    (reset),
        .wr       (lcd_bus.timer),
        .lcd_rs   (lcd_rs),
        .lcd_data (lcd_data),
        .lcd_e    (lcd_e)
    );

    // Write only
    assign lcd_rw = 1'b0;

endmodule

// ==== pet/button_sync.sv ====
module button_sync (
    input  logic clk,
    input  logic reset,
    input  logic presence,
    input  logic play,
    input  logic feed_n,
    input  logic heal_n,
    output logic awake,
    output logic feed_press,
    output logic heal_press,
    output logic play_press
);

    // Bit order heal_n, feed_n, play, presence
    localparam logic [3:0] IDLE_LEVEL = 4'b1100;

    logic [3:0] meta;
    logic [3:0] sync;
    // Previous synced value of the three buttons
    logic [2:0] sync_q;

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            meta       <= IDLE_LEVEL;
            sync       <= IDLE_LEVEL;
            sync_q     <= IDLE_LEVEL[3:1];
            feed_press <= 1'b0;
            heal_press <= 1'b0;
            play_press <= 1'b0;
        end else begin
            meta   <= {heal_n, feed_n, play, presence};
            sync   <= meta;
            sync_q <= sync[3:1];
            // Buttons are active low, act on the press edge
            heal_press <= sync_q[2] & ~sync[3];
            feed_press <= sync_q[1] & ~sync[2];
            play_press <= ~sync_q[0] & sync[1];
        end
    end

    assign awake = sync[0];

endmodule

// ==== pet/pet_stats.sv ====
module pet_stats #(
    parameter int tick_cycles = 50_000_000
) (
    input  logic           clk,
    input  logic           reset,
    input  logic           awake,
    input  logic           feed_press,
    input  logic           heal_press,
    input  logic           play_press,
    output pet_pkg::stat_t hunger,
    output pet_pkg::stat_t fun,
    output pet_pkg::stat_t energy,
    output pet_pkg::stat_t happiness,
    output pet_pkg::stat_t life,
    output pet_pkg::mood_t mood
);
    import pet_pkg::*;

    localparam int DIV_W = $clog2(tick_cycles + 1);

    logic [DIV_W-1:0] div_count;
    logic             tick_pulse;
    tick_count_t      tick_count;

    stat_t hunger_d;
    stat_t fun_d;
    stat_t energy_d;
    stat_t happiness_d;
    stat_t life_d;

    function automatic stat_t dec(stat_t v);
        return (v == '0) ? v : stat_t'(v - 4'd1);
    endfunction

    function automatic stat_t inc(stat_t v);
        return (v >= STAT_MAX) ? STAT_MAX : stat_t'(v + 4'd1);
    endfunction

    function automatic logic due(tick_count_t count, tick_count_t period);
        return (count % period) == '0;
    endfunction

    // Tick pulse, one clock wide, count already advanced when it is seen
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            div_count  <= '0;
            tick_pulse <= 1'b0;
            tick_count <= '0;
        end else if (div_count == DIV_W'(tick_cycles - 1)) begin
            div_count  <= '0;
            tick_pulse <= 1'b1;
            tick_count <= tick_count + 16'd1;
        end else begin
            div_count  <= div_count + 1'b1;
            tick_pulse <= 1'b0;
        end
    end

    always_comb begin
        hunger_d    = hunger;
        fun_d       = fun;
        energy_d    = energy;
        happiness_d = happiness;
        life_d      = life;

        // Decay, conditions use the values before the tick
        if (tick_pulse) begin
            if (due(tick_count, HUNGER_PERIOD))
                hunger_d = dec(hunger);
            if (awake && due(tick_count, FUN_PERIOD))
                fun_d = dec(fun);
            if (awake && due(tick_count, ENERGY_PERIOD))
                energy_d = dec(energy);
            else if (!awake && due(tick_count, REST_PERIOD))
                energy_d = inc(energy);
            if (due(tick_count, HAPPY_PERIOD) && (fun <= STAT_LOW || hunger <= STAT_LOW))
                happiness_d = dec(happiness);
            if (due(tick_count, LIFE_PERIOD) &&
                (hunger <= STAT_LOW || energy <= STAT_LOW || happiness <= STAT_LOW))
                life_d = dec(life);
        end

        // Presses override the tick for what they touch
        if (feed_press && awake)
            hunger_d = STAT_MAX;
        if (heal_press && life < STAT_MAX && hunger != '0) begin
            life_d   = STAT_MAX;
            hunger_d = dec(hunger);
        end
        if (play_press && awake && fun < STAT_MAX) begin
            fun_d       = STAT_MAX;
            happiness_d = inc(happiness);
            energy_d    = dec(energy);
        end
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            hunger    <= STAT_MAX;
            fun       <= STAT_MAX;
            energy    <= STAT_MAX;
            happiness <= STAT_MAX;
            life      <= STAT_MAX;
        end else if (life != '0) begin
            // A dead pet stays frozen
            hunger    <= hunger_d;
            fun       <= fun_d;
            energy    <= energy_d;
            happiness <= happiness_d;
            life      <= life_d;
        end
    end

    always_comb begin
        if (life == '0)
            mood = MOOD_DEAD;
        else if (!awake)
            mood = MOOD_ASLEEP;
        else if (happiness <= STAT_LOW)
            mood = MOOD_SAD;
        else if (life <= STAT_LOW)
            mood = MOOD_SICK;
        else if (hunger <= STAT_LOW)
            mood = MOOD_HUNGRY;
        else if (energy <= STAT_LOW)
            mood = MOOD_TIRED;
        else if (fun <= STAT_LOW)
            mood = MOOD_BORED;
        else
            mood = MOOD_HAPPY;
    end

endmodule

// ==== run.sh ====
#!/bin/sh
# Builds and runs the pet controller testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -f tb.f --top-module pet_tb -o pet_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/pet_sim > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "tests failed" "$LOG"; then
    echo "simulation FAILED"
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "simulator exited with status $status"
    exit 1
fi
echo "simulation passed"
exit 0

// ==== tb.f ====
common/pet_pkg.sv
common/lcd_pkg.sv
common/lcd_write_if.sv
pet/button_sync.sv
pet/pet_stats.sv
lcd/mood_rom.sv
lcd/lcd_sequencer.sv
lcd/lcd_bus_timer.sv
logic/pet_top.sv
tests/pet_tb.sv

// ==== tests/pet_tb.sv ====
module pet_tb;
    import pet_pkg::*;

    localparam int TICK_CYCLES = 64;
    localparam int DRAW_BYTES  = 24;
    localparam int WAIT_LIMIT  = 20000;

    typedef enum logic [1:0] {
        ACT_NONE,
        ACT_FEED,
        ACT_HEAL,
        ACT_PLAY
    } action_t;

    // Expected values are the state after the row's wait
    typedef struct packed {
        logic       presence;
        action_t    action;
        logic [7:0] ticks;
        logic       check_draw;
        stat_t      hunger;
        stat_t      fun;
        stat_t      energy;
        stat_t      happiness;
        stat_t      life;
        mood_t      mood;
    } step_t;

    logic       clk;
    logic       reset;
    logic       presence;
    logic       play;
    logic       feed_n;
    logic       heal_n;
    logic       lcd_rs;
    logic       lcd_rw;
    logic       lcd_e;
    logic [7:0] lcd_data;
    stat_t      hunger;
    stat_t      fun;
    stat_t      energy;
    stat_t      happiness;
    stat_t      life;

    int         cycle;
    logic [8:0] lcd_log [$];
    logic [7:0] glyph_ref [0:63];
    logic [7:0] text_ref [0:95];
    step_t      steps [$];

    pet_top #(
        .tick_cycles     (TICK_CYCLES),
        .power_up_cycles (10),
        .e_pulse_cycles  (2),
        .e_gap_cycles    (3)
    ) uut (
        .clk       (clk),
        .reset     (reset),
        .presence  (presence),
        .play      (play),
        .feed_n    (feed_n),
        .heal_n    (heal_n),
        .lcd_rs    (lcd_rs),
        .lcd_rw    (lcd_rw),
        .lcd_e     (lcd_e),
        .lcd_data  (lcd_data),
        .hunger    (hunger),
        .fun       (fun),
        .energy    (energy),
        .happiness (happiness),
        .life      (life)
    );

    always #10 clk = ~clk;

    // Counts clocks from reset release like the tick divider
    always @(posedge clk or negedge reset) begin
        if (!reset)
            cycle <= 0;
        else
            cycle <= cycle + 1;
    end

    // LCD pins are only valid at the falling edge of the enable
    always @(negedge lcd_e) begin
        if (reset)
            lcd_log.push_back({lcd_rs, lcd_data});
    end

    task automatic abort_run();
        $display("tests failed");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic check(input int actual, input int expected, input string what);
        if (actual != expected) begin
            $display("mismatch at time %0t: %s, got %0h, expected %0h",
                     $time, what, actual, expected);
            abort_run();
        end
    endtask

    task automatic step_clocks(input int n);
        repeat (n) begin
            @(posedge clk);
            #2;
        end
    endtask

    task automatic wait_for_cycle(input int target);
        int guard;
        guard = 0;
        while (cycle < target) begin
            step_clocks(1);
            guard++;
            if (guard > WAIT_LIMIT) begin
                $display("timeout while waiting for clock cycle %0d", target);
                abort_run();
            end
        end
        if (cycle != target) begin
            $display("schedule overrun, cycle %0d is past target %0d", cycle, target);
            abort_run();
        end
    endtask

    task automatic wait_for_bytes(input int count);
        int guard;
        guard = 0;
        while (lcd_log.size() < count) begin
            step_clocks(1);
            guard++;
            if (guard > WAIT_LIMIT) begin
                $display("timeout while waiting for %0d LCD bytes", count);
                abort_run();
            end
        end
    endtask

    // Byte k of a draw with rs in bit 8
    function automatic logic [8:0] draw_byte(input mood_t m, input int k);
        logic [5:0] g;
        logic [6:0] t;
        g = 6'(int'(m) * 8 + k - 1);
        t = 7'(int'(m) * 12 + k - 12);
        if (k == 0)
            return {1'b0, 8'h40};
        else if (k <= 8)
            return {1'b1, glyph_ref[g]};
        else if (k == 9)
            return {1'b0, 8'h80};
        else if (k == 10)
            return {1'b1, 8'h00};
        else if (k == 11)
            return {1'b0, 8'h82};
        else
            return {1'b1, text_ref[t]};
    endfunction

    task automatic check_draw(input int start, input mood_t m);
        for (int k = 0; k < DRAW_BYTES; k++) begin
            check(int'(lcd_log[start + k]), int'(draw_byte(m, k)),
                  $sformatf("LCD byte %0d of the mood %0d draw", k, int'(m)));
        end
    endtask

    task automatic apply_action(input action_t act);
        if (act != ACT_NONE) begin
            // Short idle gap so the press still lands well before the next tick
            step_clocks(int'($urandom % 8));
            case (act)
                ACT_FEED: feed_n = 1'b0;
                ACT_HEAL: heal_n = 1'b0;
                default:  play = 1'b1;
            endcase
            step_clocks(2);
            feed_n = 1'b1;
            heal_n = 1'b1;
            play   = 1'b0;
            step_clocks(4);
        end
    endtask

    task automatic add_step(input logic p, input action_t a, input int t, input logic d,
                            input int h, input int f, input int e, input int ha,
                            input int l, input mood_t m);
        step_t s;
        s.presence   = p;
        s.action     = a;
        s.ticks      = 8'(t);
        s.check_draw = d;
        s.hunger     = stat_t'(h);
        s.fun        = stat_t'(f);
        s.energy     = stat_t'(e);
        s.happiness  = stat_t'(ha);
        s.life       = stat_t'(l);
        s.mood       = m;
        steps.push_back(s);
    endtask

    task automatic check_row(input int row, input step_t s);
        check(int'(hunger), int'(s.hunger), $sformatf("row %0d hunger", row));
        check(int'(fun), int'(s.fun), $sformatf("row %0d fun", row));
        check(int'(energy), int'(s.energy), $sformatf("row %0d energy", row));
        check(int'(happiness), int'(s.happiness), $sformatf("row %0d happiness", row));
        check(int'(life), int'(s.life), $sformatf("row %0d life", row));
        check(int'(uut.u_stats.mood), int'(s.mood), $sformatf("row %0d mood", row));
    endtask

    initial begin
        step_t s;
        int    tick_now;
        int    mark;
        int    log_end;

        clk      = 1'b0;
        reset    = 1'b0;
        presence = 1'b1;
        play     = 1'b0;
        feed_n   = 1'b1;
        heal_n   = 1'b1;
        void'($urandom(32'h3fa6));

        $readmemh("lcd/mood_glyphs.mem", glyph_ref);
        $readmemh("lcd/mood_text.mem", text_ref);

        // Awake decay from the state after tick 4
        add_step(1'b1, ACT_NONE, 0, 1'b0, 4, 4, 5, 5, 5, MOOD_HAPPY);
        add_step(1'b1, ACT_NONE, 4, 1'b0, 3, 3, 4, 5, 5, MOOD_HAPPY);
        add_step(1'b1, ACT_NONE, 4, 1'b0, 2, 2, 4, 5, 5, MOOD_HUNGRY);
        // Low fun costs happiness at tick 16
        add_step(1'b1, ACT_FEED, 4, 1'b0, 4, 1, 3, 4, 5, MOOD_BORED);
        add_step(1'b1, ACT_PLAY, 0, 1'b0, 4, 5, 2, 5, 5, MOOD_TIRED);
        add_step(1'b1, ACT_NONE, 4, 1'b0, 3, 4, 2, 5, 5, MOOD_TIRED);
        add_step(1'b1, ACT_NONE, 4, 1'b0, 2, 3, 1, 5, 4, MOOD_HUNGRY);
        add_step(1'b1, ACT_HEAL, 0, 1'b0, 1, 3, 1, 5, 5, MOOD_HUNGRY);
        add_step(1'b1, ACT_FEED, 4, 1'b0, 4, 2, 1, 5, 5, MOOD_TIRED);
        add_step(1'b1, ACT_NONE, 4, 1'b0, 3, 1, 0, 4, 4, MOOD_TIRED);
        // Feed has no effect while asleep and energy recovers every 2 ticks
        add_step(1'b0, ACT_FEED, 4, 1'b1, 2, 1, 2, 3, 4, MOOD_ASLEEP);
        add_step(1'b0, ACT_NONE, 2, 1'b0, 2, 1, 3, 3, 4, MOOD_ASLEEP);
        // Neglect drains life and heal needs hunger above 0
        add_step(1'b0, ACT_NONE, 10, 1'b0, 0, 1, 5, 0, 2, MOOD_ASLEEP);
        add_step(1'b0, ACT_HEAL, 8, 1'b0, 0, 1, 5, 0, 1, MOOD_ASLEEP);
        add_step(1'b0, ACT_NONE, 12, 1'b1, 0, 1, 5, 0, 0, MOOD_DEAD);
        // Dead pet stays frozen
        add_step(1'b1, ACT_FEED, 8, 1'b0, 0, 1, 5, 0, 0, MOOD_DEAD);
        add_step(1'b1, ACT_PLAY, 4, 1'b0, 0, 1, 5, 0, 0, MOOD_DEAD);

        repeat (8) @(posedge clk);
        #2;
        reset = 1'b1;
        step_clocks(1);

        check(int'(hunger), 5, "hunger after reset");
        check(int'(fun), 5, "fun after reset");
        check(int'(energy), 5, "energy after reset");
        check(int'(happiness), 5, "happiness after reset");
        check(int'(life), 5, "life after reset");
        check(int'(lcd_rw), 0, "lcd_rw");

        // Init commands and then the first happy draw
        wait_for_bytes(3 + DRAW_BYTES);
        check(int'(lcd_log[0]), 'h038, "first init command");
        check(int'(lcd_log[1]), 'h00c, "second init command");
        check(int'(lcd_log[2]), 'h001, "third init command");
        check_draw(3, MOOD_HAPPY);
        log_end = 3 + DRAW_BYTES;

        tick_now = 4;
        wait_for_cycle(tick_now * TICK_CYCLES + TICK_CYCLES / 2);

        for (int i = 0; i < steps.size(); i++) begin
            s        = steps[i];
            mark     = lcd_log.size();
            presence = s.presence;
            apply_action(s.action);
            tick_now = tick_now + int'(s.ticks);
            // Sample in the middle of the tick interval
            if (s.ticks != 0)
                wait_for_cycle(tick_now * TICK_CYCLES + TICK_CYCLES / 2);
            check_row(i, s);
            if (s.check_draw) begin
                check(lcd_log.size(), mark + DRAW_BYTES,
                      $sformatf("row %0d LCD byte count", i));
                check_draw(mark, s.mood);
                log_end = mark + DRAW_BYTES;
            end
        end

        // No redraw once the pet is dead
        check(lcd_log.size(), log_end, "LCD byte count at the end");

        $display("all tests passed");
        $finish;
    end

endmodule
